/* fetch_pkg.sv */
package fetch_pkg;

    // byte address and data widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;

    // delivered instruction with a compressed one in the low half
    typedef logic [31:0] insn_t;

    // instruction memory size in words
    localparam int MEM_WORDS = 256;
    localparam int IDX_W = $clog2(MEM_WORDS);

    // pc after reset
    localparam addr_t BOOT_ADDR = 32'h0000_0000;

    // fetch side request into the instruction memory
    typedef struct packed {
        logic  ren;
        addr_t addr;
    } mem_req_t;

    // memory response where rdata only counts while ren is high and busy low
    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

    // instruction handed to the decode stage
    typedef struct packed {
        logic  valid;
        logic  compressed;
        insn_t insn;
        addr_t pc;
    } fetch_out_t;

endpackage

/* pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             en,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             insn_valid,
    input  logic             insn_compressed,
    output fetch_pkg::addr_t pc
);

    fetch_pkg::addr_t pc_next;
    fetch_pkg::addr_t step;

    // instruction length in bytes
    assign step = insn_compressed ? 32'd2 : 32'd4;

    always_comb begin
        pc_next = pc;
        if (redirect) begin
            // targets are halfword aligned
            pc_next = {redirect_pc[31:1], 1'b0};
        end else if (en && insn_valid) begin
            pc_next = pc + step;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= fetch_pkg::BOOT_ADDR;
        end else begin
            pc <= pc_next;
        end
    end

    // halfword alignment must hold through resets, redirects and steps
    a_pc_half_aligned: assert property (
        @(posedge CLK) disable iff (!nRST)
        pc[0] == 1'b0
    );

endmodule

/* fetch_buffer.sv */
`timescale 1ns/1ps

module fetch_buffer (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 ren,
    input  logic                 invalidate,
    input  fetch_pkg::addr_t     pc,
    input  fetch_pkg::mem_rsp_t  rsp,
    output logic                 insn_valid,
    output logic                 insn_compressed,
    output fetch_pkg::insn_t     insn_out,
    output fetch_pkg::mem_req_t  req
);

    // one spare halfword left over from the last word read
    typedef struct packed {
        fetch_pkg::half_t data;
        logic             valid;
    } hbuf_t;

    hbuf_t            fb;
    hbuf_t            fb_next;
    logic             pc_aligned;
    logic             want_fetch;
    fetch_pkg::addr_t fetch_addr;

    function automatic logic is_compressed(fetch_pkg::half_t chunk);
        return (chunk[1:0] != 2'b11);
    endfunction

    assign pc_aligned = ~pc[1];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fb <= '0;
        end else begin
            fb <= fb_next;
        end
    end

    always_comb begin
        fb_next         = fb;
        fetch_addr      = pc;
        want_fetch      = 1'b0;
        insn_out        = '0;
        insn_valid      = 1'b0;
        insn_compressed = 1'b0;

        if (invalidate) begin
            // drop whatever was left from the old stream
            fb_next.valid = 1'b0;
        end else if (ren) begin
            if (pc_aligned) begin
                // whole word at pc and the buffer stays unused
                want_fetch = 1'b1;
                if (!rsp.busy) begin
                    insn_valid = 1'b1;
                    if (is_compressed(rsp.rdata[15:0])) begin
                        insn_out        = {16'h0000, rsp.rdata[15:0]};
                        insn_compressed = 1'b1;
                        // keep the upper half for the next pc
                        fb_next.valid   = 1'b1;
                        fb_next.data    = rsp.rdata[31:16];
                    end else begin
                        insn_out      = rsp.rdata;
                        fb_next.valid = 1'b0;
                    end
                end
            end else if (fb.valid) begin
                if (is_compressed(fb.data)) begin
                    // buffered half is a full instruction and needs no memory access
                    insn_out        = {16'h0000, fb.data};
                    insn_compressed = 1'b1;
                    insn_valid      = 1'b1;
                    fb_next.valid   = 1'b0;
                end else begin
                    // lower half is buffered and the upper half is in the next word
                    want_fetch = 1'b1;
                    fetch_addr = pc + 32'd2;
                    if (!rsp.busy) begin
                        insn_out      = {rsp.rdata[15:0], fb.data};
                        insn_valid    = 1'b1;
                        fb_next.valid = 1'b1;
                        fb_next.data  = rsp.rdata[31:16];
                    end
                end
            end else begin
                // misaligned with nothing buffered so read the word holding pc
                want_fetch = 1'b1;
                fetch_addr = {pc[31:2], 2'b00};
                if (!rsp.busy) begin
                    if (is_compressed(rsp.rdata[31:16])) begin
                        insn_out        = {16'h0000, rsp.rdata[31:16]};
                        insn_compressed = 1'b1;
                        insn_valid      = 1'b1;
                        fb_next.valid   = 1'b0;
                    end else begin
                        // stall a cycle and come back through the buffered path
                        fb_next.valid = 1'b1;
                        fb_next.data  = rsp.rdata[31:16];
                    end
                end
            end
        end
    end

    assign req.ren  = ren & want_fetch;
    assign req.addr = fetch_addr;

    // a held half always belongs to a misaligned pc
    a_fb_misaligned: assert property (
        @(posedge CLK) disable iff (!nRST)
        fb.valid |-> (pc[1] || $past(invalidate))
    );

    // nothing is delivered while paused or during a redirect
    a_valid_gated: assert property (
        @(posedge CLK) disable iff (!nRST)
        insn_valid |-> (ren && !invalidate)
    );

endmodule

/* insn_mem.sv */
`timescale 1ns/1ps

module insn_mem #(
    parameter int unsigned WAIT_STATES = 1
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  fetch_pkg::mem_req_t           req,
    input  logic                          load_en,
    input  logic [fetch_pkg::IDX_W-1:0]   load_addr,
    input  fetch_pkg::word_t              load_data,
    output fetch_pkg::mem_rsp_t           rsp
);

    fetch_pkg::word_t              mem [fetch_pkg::MEM_WORDS];
    fetch_pkg::word_t              rdata_q;
    logic [fetch_pkg::IDX_W-1:0]   req_idx;
    logic [fetch_pkg::IDX_W-1:0]   held_idx;
    logic                          held_valid;
    logic [2:0]                    wait_cnt;
    logic                          busy;
    logic                          latch;

    // upper address bits are outside the array and ignored
    assign req_idx = req.addr[fetch_pkg::IDX_W+1:2];

    // a miss on the held word raises busy in the same cycle
    assign busy  = req.ren & ~(held_valid && (held_idx == req_idx));
    assign latch = busy && (wait_cnt == 3'(WAIT_STATES));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held_valid <= 1'b0;
            wait_cnt   <= '0;
        end else begin
            if (latch) begin
                wait_cnt   <= '0;
                held_valid <= 1'b1;
            end else if (busy) begin
                wait_cnt <= wait_cnt + 3'd1;
            end else begin
                wait_cnt <= '0;
            end
            // reloading the held word makes the copy stale
            if (load_en && (load_addr == held_idx)) begin
                held_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (latch) begin
            rdata_q  <= mem[req_idx];
            held_idx <= req_idx;
        end
    end

    always_ff @(posedge CLK) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    assign rsp.busy  = busy;
    assign rsp.rdata = rdata_q;

    // program loading and fetching never overlap
    a_no_load_during_fetch: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(load_en && req.ren)
    );

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter int unsigned WAIT_STATES = 1
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        fetch_en,
    input  logic                        redirect,
    input  fetch_pkg::addr_t            redirect_pc,
    input  logic                        load_en,
    input  logic [fetch_pkg::IDX_W-1:0] load_addr,
    input  fetch_pkg::word_t            load_data,
    output fetch_pkg::fetch_out_t       fetch_out
);

    fetch_pkg::addr_t    pc;
    fetch_pkg::insn_t    insn;
    fetch_pkg::mem_req_t mem_req;
    fetch_pkg::mem_rsp_t mem_rsp;
    logic                insn_valid;
    logic                insn_compressed;

    pc_gen pc0 (
        .CLK             (CLK),
        .nRST            (nRST),
        .en              (fetch_en),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .insn_valid      (insn_valid),
        .insn_compressed (insn_compressed),
        .pc              (pc)
    );

    // redirect also flushes the spare halfword
    fetch_buffer fb0 (
        .CLK             (CLK),
        .nRST            (nRST),
        .ren             (fetch_en),
        .invalidate      (redirect),
        .pc              (pc),
        .rsp             (mem_rsp),
        .insn_valid      (insn_valid),
        .insn_compressed (insn_compressed),
        .insn_out        (insn),
        .req             (mem_req)
    );

    insn_mem #(.WAIT_STATES(WAIT_STATES)) mem0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .req       (mem_req),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rsp       (mem_rsp)
    );

    assign fetch_out.valid      = insn_valid;
    assign fetch_out.compressed = insn_compressed;
    assign fetch_out.insn       = insn;
    assign fetch_out.pc         = pc;

endmodule

/* tb_fetch_unit.sv */
`timescale 1ns/1ps

module tb_fetch_unit;

    localparam int WAIT_STATES = 1;

    logic                        CLK;
    logic                        nRST;
    logic                        fetch_en;
    logic                        redirect;
    fetch_pkg::addr_t            redirect_pc;
    logic                        load_en;
    logic [fetch_pkg::IDX_W-1:0] load_addr;
    fetch_pkg::word_t            load_data;
    fetch_pkg::fetch_out_t       fetch_out;

    // program image and test records taken from the data file
    fetch_pkg::word_t prog[$];
    logic [127:0]     test_name[$];
    fetch_pkg::addr_t test_start[$];
    int               test_count[$];

    int     errors = 0;
    int     failed_tests = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    integer seed;
    logic   input_ok;

    fetch_unit #(.WAIT_STATES(WAIT_STATES)) dut0 (
        .CLK         (CLK),
        .nRST        (nRST),
        .fetch_en    (fetch_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .fetch_out   (fetch_out)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // watchdog armed once the test records are known
    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("Simulation failed");
        $finish;
    end

    task automatic compare_value(input logic [127:0] name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERR %0s %0s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    // halfword k of the program in little endian order within each word
    function automatic fetch_pkg::half_t half_at(input int k);
        fetch_pkg::word_t w;
        w = (k / 2 < prog.size()) ? prog[k / 2] : '0;
        return k[0] ? w[31:16] : w[15:0];
    endfunction

    task automatic read_input(output logic ok);
        integer           fd;
        integer           code;
        logic [127:0]     tag;
        logic [127:0]     name;
        logic [8*120-1:0] line;
        fetch_pkg::word_t w;
        fetch_pkg::addr_t start;
        int               count;
        ok = 1'b1;
        fd = $fopen("fetch_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open fetch_input.txt");
            ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    code = $fgets(line, fd);
                end else if (tag == "W") begin
                    code = $fscanf(fd, "%h", w);
                    if (code != 1) begin
                        $display("malformed program word in fetch_input.txt");
                        ok = 1'b0;
                    end
                    prog.push_back(w);
                end else if (tag == "T") begin
                    code = $fscanf(fd, "%s %h %d", name, start, count);
                    if (code != 3) begin
                        $display("malformed test record in fetch_input.txt");
                        ok = 1'b0;
                    end
                    test_name.push_back(name);
                    test_start.push_back(start);
                    test_count.push_back(count);
                end else begin
                    $display("unexpected record type %0s in fetch_input.txt", tag);
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input logic [127:0] name, input fetch_pkg::addr_t start,
                            input int count);
        fetch_pkg::addr_t pc_exp;
        fetch_pkg::half_t lo;
        fetch_pkg::insn_t insn_exp;
        logic             comp_exp;
        int               done;
        int               pause_at;
        int               pause_len;
        int               errors_before;
        pc_exp        = start;
        done          = 0;
        errors_before = errors;
        pause_at      = (count > 1) ? 1 + ({$random(seed)} % (count - 1)) : count + 1;
        pause_len     = 1 + ({$random(seed)} % 4);
        @(posedge CLK);
        redirect    <= 1'b1;
        redirect_pc <= start;
        @(posedge CLK);
        redirect <= 1'b0;
        fetch_en <= 1'b1;
        while (done < count) begin
            @(negedge CLK);
            if (fetch_out.valid) begin
                lo       = half_at(pc_exp >> 1);
                comp_exp = (lo[1:0] != 2'b11);
                insn_exp = comp_exp ? {16'h0000, lo} : {half_at((pc_exp >> 1) + 1), lo};
                compare_value(name, "pc", pc_exp, fetch_out.pc);
                compare_value(name, "insn", insn_exp, fetch_out.insn);
                compare_value(name, "compressed", 32'(comp_exp), 32'(fetch_out.compressed));
                pc_exp = pc_exp + (comp_exp ? 32'd2 : 32'd4);
                done++;
                if (done == pause_at) begin
                    // consumer stalls fetch for a few cycles
                    @(posedge CLK);
                    fetch_en <= 1'b0;
                    repeat (pause_len) begin
                        @(negedge CLK);
                        if (fetch_out.valid) begin
                            errors++;
                            $display("test %0s: instruction delivered while fetch was paused",
                                     name);
                        end
                    end
                    @(posedge CLK);
                    fetch_en <= 1'b1;
                end
            end
        end
        @(posedge CLK);
        fetch_en <= 1'b0;
        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("test %0s: %0d instructions, %0d mismatches", name, done,
                 errors - errors_before);
    endtask

    task automatic run_all();
        nRST <= 1'b1;
        @(negedge CLK);
        compare_value("reset", "valid", 32'd0, 32'(fetch_out.valid));
        // program goes in through the load port while fetch is off
        foreach (prog[i]) begin
            @(posedge CLK);
            load_en   <= 1'b1;
            load_addr <= (fetch_pkg::IDX_W)'(i);
            load_data <= prog[i];
        end
        @(posedge CLK);
        load_en <= 1'b0;
        foreach (test_name[t]) begin
            run_test(test_name[t], test_start[t], test_count[t]);
        end
    endtask

    initial begin
        int total;
        nRST        = 1'b0;
        fetch_en    = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        seed        = 32'hf8f760ff;
        total       = 0;
        read_input(input_ok);
        foreach (test_count[t]) begin
            total += test_count[t];
        end
        cycle_limit = total * (2 * WAIT_STATES + 4) + 200;
        repeat (10) @(posedge CLK);
        if (!input_ok) begin
            $display("Simulation failed");
        end else begin
            run_all();
            $display("tests %0d, failed %0d, mismatches %0d", test_name.size(),
                     failed_tests, errors);
            if (errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule

/* filelist.f */
fetch_pkg.sv
pc_gen.sv
fetch_buffer.sv
insn_mem.sv
fetch_unit.sv
tb_fetch_unit.sv

/* fetch_input.txt */
# W <word hex>                   program word, loaded at consecutive word indexes from 0
# T <name> <start hex> <count>   test record, redirect to start and check count instructions
# aligned 32-bit instructions
W 00100093
W 00200113
W 00300193
W 00400213
# two compressed instructions per word
W 45054485
W 46054585
W 00000013
W 00000013
# compressed, then a 32-bit instruction straddling words 8 and 9, then compressed
W 02934685
W 47050050
W 00000013
# full-width run from a word boundary
T aligned32 00000000 4
# compressed pairs, leaves a spare half in the buffer
T cpairs 00000010 3
# misaligned redirect onto a compressed instruction
T redir_c 00000012 2
# misaligned redirect onto a full instruction
T redir_full 00000022 2
# straddling instruction after a compressed one
T straddle 00000020 3
